// File: logic/psx_loader_settings.svh
//========================================
// loader widths, memory region offsets
// and framebuffer constants
//========================================
`ifndef PSX_LOADER_SETTINGS_SVH
`define PSX_LOADER_SETTINGS_SVH

// loader stream and memory bus
`define PSX_ADDR_W 27
`define PSX_HALF_W 16
`define PSX_WORD_W 32
`define PSX_INDEX_W 8

// image regions inside main memory
`define PSX_BIOS_START 2097152
`define PSX_EXE_START 4194304

// disc image size as seen by the core
`define PSX_CD_SIZE_W 30

// framebuffer in ddr3, 16 bit pixels
`define PSX_FB_BASE 32'h30000000
`define PSX_FB_LINE_BYTES 2048
`define PSX_FB_GEOM_W 12
`define PSX_VRAM_WIDTH 1024
`define PSX_VRAM_HEIGHT 512

// display offsets from the gpu
`define PSX_DISP_OFFX_W 10
`define PSX_DISP_OFFY_W 9

`endif

// File: logic/psx_loader_pkg.sv
//========================================
// download kinds, fb formats, bus structs
//========================================
`default_nettype none
`include "psx_loader_settings.svh"

package psx_loader_pkg;

	// decoded from the host file index
	typedef enum logic [1:0] {
		DL_NONE = 2'd0,
		DL_BIOS = 2'd1,
		DL_EXE  = 2'd2,
		DL_CD   = 2'd3
	} dl_kind_e;

	// scaler pixel formats, bit3 selects 1555, low bits the depth
	typedef enum logic [4:0] {
		FB_FMT_16 = 5'b01100,
		FB_FMT_24 = 5'b00101
	} fb_fmt_e;

	// one halfword from the host loader
	typedef struct packed {
		logic                    wr;
		logic [`PSX_ADDR_W-1:0]  addr;
		logic [`PSX_HALF_W-1:0]  data;
		logic [`PSX_INDEX_W-1:0] index;
	} loader_beat_t;

	// full word toward a memory channel
	typedef struct packed {
		logic                   req;
		logic [`PSX_ADDR_W-1:0] addr;
		logic [`PSX_WORD_W-1:0] data;
	} ram_write_t;

	typedef struct packed {
		logic                      en;
		logic [4:0]                format;
		logic [`PSX_FB_GEOM_W-1:0] width;
		logic [`PSX_FB_GEOM_W-1:0] height;
		logic [31:0]               base;
	} fb_cfg_t;

	// user menu options
	typedef struct packed {
		logic fb_on;
		logic color24;
		logic vram_view;
	} fb_opts_t;

	typedef struct packed {
		logic [`PSX_FB_GEOM_W-1:0]   width;
		logic [`PSX_FB_GEOM_W-1:0]   height;
		logic [`PSX_DISP_OFFX_W-1:0] offset_x;
		logic [`PSX_DISP_OFFY_W-1:0] offset_y;
	} disp_geom_t;

endpackage

`default_nettype wire

// File: logic/download_decode.sv
//========================================
// download type decode, core reset hold,
// exe start pulse and disc size capture
//========================================
`timescale 1ns/10ps
`default_nettype none
`include "psx_loader_settings.svh"

module download_decode (
	input  wire                                clk_1x,
	input  wire                                arst_n,
	input  wire                                download,
	input  wire psx_loader_pkg::loader_beat_t  beat,
	output psx_loader_pkg::dl_kind_e           dl_kind,
	output logic                               core_reset,
	output logic                               exe_load,
	output logic [`PSX_CD_SIZE_W-1:0]          cd_size
);

	psx_loader_pkg::dl_kind_e kind_next;
	psx_loader_pkg::dl_kind_e kind_prev;
	logic [`PSX_ADDR_W-1:0]   last_addr;
	logic                     exe_end;
	logic                     cd_end;

	//========================================
	// index decode
	//========================================
	always_comb begin
		kind_next = psx_loader_pkg::DL_NONE;
		if (download) begin
			// index 0 bios, 1 exe, any slot ending in 2 is a disc
			if (beat.index == `PSX_INDEX_W'(0)) begin
				kind_next = psx_loader_pkg::DL_BIOS;
			end else if (beat.index == `PSX_INDEX_W'(1)) begin
				kind_next = psx_loader_pkg::DL_EXE;
			end else if (beat.index[5:0] == 6'd2) begin
				kind_next = psx_loader_pkg::DL_CD;
			end
		end
	end

	// end of a download seen one cycle after dl_kind drops
	assign exe_end = (kind_prev == psx_loader_pkg::DL_EXE) &&
	                 (dl_kind != psx_loader_pkg::DL_EXE);
	assign cd_end  = (kind_prev == psx_loader_pkg::DL_CD) &&
	                 (dl_kind != psx_loader_pkg::DL_CD);

	//========================================
	// control registers
	//========================================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_kind    <= psx_loader_pkg::DL_NONE;
			kind_prev  <= psx_loader_pkg::DL_NONE;
			core_reset <= 1'b0;
			exe_load   <= 1'b0;
			cd_size    <= '0;
		end else begin
			dl_kind    <= kind_next;
			kind_prev  <= dl_kind;
			// core held in reset for the whole download
			core_reset <= (kind_next != psx_loader_pkg::DL_NONE);
			exe_load   <= exe_end;
			if (cd_end) begin
				cd_size <= `PSX_CD_SIZE_W'(last_addr);
			end
		end
	end

	// address of the final disc beat
	always_ff @(posedge clk_1x) begin
		if (beat.wr && (dl_kind == psx_loader_pkg::DL_CD)) begin
			last_addr <= beat.addr;
		end
	end

endmodule

`default_nettype wire

// File: logic/word_packer.sv
//========================================
// halfword pairing into 32 bit writes,
// loader wait flag
//========================================
`timescale 1ns/10ps
`default_nettype none
`include "psx_loader_settings.svh"

module word_packer (
	input  wire                                clk_1x,
	input  wire                                arst_n,
	input  wire psx_loader_pkg::loader_beat_t  beat,
	input  wire psx_loader_pkg::dl_kind_e      dl_kind,
	input  wire                                wr_ack,
	output psx_loader_pkg::ram_write_t         wr,
	output logic                               load_wait
);

	logic                   active;
	logic                   accept;
	logic                   odd_half;
	logic [`PSX_ADDR_W-1:0] region_off;
	logic [`PSX_ADDR_W-1:0] word_addr;
	logic [`PSX_HALF_W-1:0] lo_half;
	logic [`PSX_WORD_W-1:0] word_data;
	logic                   req_q;

	// beats outside a known download are dropped
	assign active   = (dl_kind != psx_loader_pkg::DL_NONE);
	assign accept   = beat.wr && active;
	// address bit 1 picks the half of the word
	assign odd_half = beat.addr[1];

	//========================================
	// region offset per image type
	//========================================
	always_comb begin
		case (dl_kind)
			psx_loader_pkg::DL_BIOS: begin
				region_off = `PSX_ADDR_W'(`PSX_BIOS_START);
			end
			psx_loader_pkg::DL_EXE: begin
				region_off = `PSX_ADDR_W'(`PSX_EXE_START);
			end
			// disc memory starts at zero
			default: begin
				region_off = '0;
			end
		endcase
	end

	//========================================
	// word assembly
	//========================================
	always_ff @(posedge clk_1x) begin
		if (accept && !odd_half) begin
			lo_half   <= beat.data;
			word_addr <= beat.addr + region_off;
		end
		// high half lands on top, low half from the even beat
		if (accept && odd_half) begin
			word_data <= {beat.data, lo_half};
		end
	end

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			req_q     <= 1'b0;
			load_wait <= 1'b0;
		end else begin
			// one strobe per completed word
			req_q <= accept && odd_half;
			if (!active) begin
				load_wait <= 1'b0;
			end else if (accept && odd_half) begin
				load_wait <= 1'b1;
			end else if (wr_ack) begin
				// host released the cycle after the memory ack
				load_wait <= 1'b0;
			end
		end
	end

	assign wr = '{req: req_q, addr: word_addr, data: word_data};

	// host loader honours the wait flag
	a_no_beat_in_wait: assert property (@(posedge clk_1x) disable iff (!arst_n)
		load_wait |-> !beat.wr)
		else $error("loader strobe while wait is high");

endmodule

`default_nettype wire

// File: logic/ram_write_router.sv
//========================================
// main / disc channel steering, ack merge
//========================================
`timescale 1ns/10ps
`default_nettype none
`include "psx_loader_settings.svh"

module ram_write_router (
	input  wire                              clk_1x,
	input  wire                              arst_n,
	input  wire psx_loader_pkg::ram_write_t  wr,
	input  wire psx_loader_pkg::dl_kind_e    dl_kind,
	input  wire                              main_ack,
	input  wire                              cd_ack,
	output psx_loader_pkg::ram_write_t       main_wr,
	output psx_loader_pkg::ram_write_t       cd_wr,
	output logic                             wr_ack
);

	logic                   to_main;
	logic                   to_cd;
	logic                   main_req_q;
	logic                   cd_req_q;
	logic [`PSX_ADDR_W-1:0] addr_q;
	logic [`PSX_WORD_W-1:0] data_q;
	logic                   pending;
	logic                   pend_cd;

	// bios and exe share main memory
	assign to_main = wr.req && ((dl_kind == psx_loader_pkg::DL_BIOS) ||
	                            (dl_kind == psx_loader_pkg::DL_EXE));
	assign to_cd   = wr.req && (dl_kind == psx_loader_pkg::DL_CD);

	// only the channel that holds the write may finish it
	assign wr_ack = pending && (pend_cd ? cd_ack : main_ack);

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			main_req_q <= 1'b0;
			cd_req_q   <= 1'b0;
			pending    <= 1'b0;
			pend_cd    <= 1'b0;
		end else begin
			main_req_q <= to_main;
			cd_req_q   <= to_cd;
			if (to_main || to_cd) begin
				pending <= 1'b1;
				pend_cd <= to_cd;
			end else if (wr_ack) begin
				pending <= 1'b0;
			end
		end
	end

	// shared payload, one word in flight
	always_ff @(posedge clk_1x) begin
		if (wr.req) begin
			addr_q <= wr.addr;
			data_q <= wr.data;
		end
	end

	assign main_wr = '{req: main_req_q, addr: addr_q, data: data_q};
	assign cd_wr   = '{req: cd_req_q, addr: addr_q, data: data_q};

	a_no_overlap: assert property (@(posedge clk_1x) disable iff (!arst_n)
		wr.req |-> !pending)
		else $error("new write while previous one is outstanding");

	a_ack_in_flight: assert property (@(posedge clk_1x) disable iff (!arst_n)
		(main_ack || cd_ack) |-> pending)
		else $error("channel ack with no write outstanding");

endmodule

`default_nettype wire

// File: logic/framebuffer_setup.sv
//========================================
// framebuffer format, geometry and base
//========================================
`timescale 1ns/10ps
`default_nettype none
`include "psx_loader_settings.svh"

module framebuffer_setup (
	input  wire                              clk_1x,
	input  wire                              arst_n,
	input  wire psx_loader_pkg::fb_opts_t    fb_opts,
	input  wire psx_loader_pkg::disp_geom_t  disp,
	output psx_loader_pkg::fb_cfg_t          fb_cfg
);

	psx_loader_pkg::fb_cfg_t cfg_next;
	logic [31:0]             off_x_bytes;
	logic [31:0]             off_y_bytes;

	//========================================
	// display window origin in bytes
	//========================================
	// two bytes per pixel
	assign off_x_bytes = {{(31 - `PSX_DISP_OFFX_W){1'b0}}, disp.offset_x, 1'b0};
	// fixed line stride
	assign off_y_bytes = 32'(disp.offset_y) * 32'(`PSX_FB_LINE_BYTES);

	always_comb begin
		cfg_next.en = fb_opts.fb_on;
		if (fb_opts.color24) begin
			cfg_next.format = psx_loader_pkg::FB_FMT_24;
		end else begin
			cfg_next.format = psx_loader_pkg::FB_FMT_16;
		end
		if (fb_opts.vram_view) begin
			// whole 1024x512 vram
			cfg_next.width  = `PSX_FB_GEOM_W'(`PSX_VRAM_WIDTH);
			cfg_next.height = `PSX_FB_GEOM_W'(`PSX_VRAM_HEIGHT);
			cfg_next.base   = `PSX_FB_BASE;
		end else begin
			// visible display area only
			cfg_next.width  = disp.width;
			cfg_next.height = disp.height;
			cfg_next.base   = `PSX_FB_BASE + off_x_bytes + off_y_bytes;
		end
	end

	//========================================
	// output register
	//========================================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			fb_cfg <= '0;
		end else begin
			fb_cfg <= cfg_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/psx_loader_top.sv
//========================================
// loader front end, top level
//========================================
`timescale 1ns/10ps
`default_nettype none
`include "psx_loader_settings.svh"

module psx_loader_top (
	input  wire                              clk_1x,
	input  wire                              arst_n,
	// host loader
	input  wire                              download,
	input  wire psx_loader_pkg::loader_beat_t beat,
	output wire                              load_wait,
	// main memory write channel
	output psx_loader_pkg::ram_write_t       main_wr,
	input  wire                              main_ack,
	// disc memory write channel
	output psx_loader_pkg::ram_write_t       cd_wr,
	input  wire                              cd_ack,
	// core control
	output wire                              exe_load,
	output wire                              core_reset,
	output wire [`PSX_CD_SIZE_W-1:0]         cd_size,
	// framebuffer
	input  wire psx_loader_pkg::fb_opts_t    fb_opts,
	input  wire psx_loader_pkg::disp_geom_t  disp,
	output psx_loader_pkg::fb_cfg_t          fb_cfg
);

	wire psx_loader_pkg::dl_kind_e   dl_kind;
	wire psx_loader_pkg::ram_write_t packed_wr;
	wire                             wr_ack;

	//========================================
	// download path
	//========================================
	download_decode u_decode (
		.clk_1x     (clk_1x),
		.arst_n     (arst_n),
		.download   (download),
		.beat       (beat),
		.dl_kind    (dl_kind),
		.core_reset (core_reset),
		.exe_load   (exe_load),
		.cd_size    (cd_size)
	);

	// halfwords in, words out
	word_packer u_packer (
		.clk_1x    (clk_1x),
		.arst_n    (arst_n),
		.beat      (beat),
		.dl_kind   (dl_kind),
		.wr_ack    (wr_ack),
		.wr        (packed_wr),
		.load_wait (load_wait)
	);

	ram_write_router u_router (
		.clk_1x   (clk_1x),
		.arst_n   (arst_n),
		.wr       (packed_wr),
		.dl_kind  (dl_kind),
		.main_ack (main_ack),
		.cd_ack   (cd_ack),
		.main_wr  (main_wr),
		.cd_wr    (cd_wr),
		.wr_ack   (wr_ack)
	);

	//========================================
	// video setup
	//========================================
	framebuffer_setup u_fb (
		.clk_1x  (clk_1x),
		.arst_n  (arst_n),
		.fb_opts (fb_opts),
		.disp    (disp),
		.fb_cfg  (fb_cfg)
	);

endmodule

`default_nettype wire

// File: dv/mem_ack_model.sv
//========================================
// memory channel ack with random latency
//========================================
`timescale 1ns/10ps
`default_nettype none

module mem_ack_model (
	input  wire  clk_1x,
	input  wire  arst_n,
	input  wire  main_req,
	input  wire  cd_req,
	output logic main_ack,
	output logic cd_ack
);

	// fixed seed, same latencies every run
	integer     seed = 18;
	logic       busy;
	logic       to_cd;
	logic [2:0] cnt;

	always @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			main_ack <= 1'b0;
			cd_ack   <= 1'b0;
			busy     <= 1'b0;
			to_cd    <= 1'b0;
			cnt      <= 3'd0;
		end else begin
			main_ack <= 1'b0;
			cd_ack   <= 1'b0;
			if (!busy) begin
				// latency of 1 to 6 cycles per write
				if (main_req || cd_req) begin
					busy  <= 1'b1;
					to_cd <= cd_req;
					cnt   <= 3'(1 + ($unsigned($random(seed)) % 6));
				end
			end else if (cnt == 3'd1) begin
				busy <= 1'b0;
				// ack goes back on the channel that asked
				if (to_cd) begin
					cd_ack <= 1'b1;
				end else begin
					main_ack <= 1'b1;
				end
			end else begin
				cnt <= cnt - 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/psx_loader_tb.sv
//========================================
// loader front end testbench, case table
//========================================
`timescale 1ns/10ps
`default_nettype none

module psx_loader_tb;

	localparam int          N_CASES = 7;
	localparam logic [1:0]  CH_NONE = 2'd0;
	localparam logic [1:0]  CH_MAIN = 2'd1;
	localparam logic [1:0]  CH_CD   = 2'd2;
	localparam logic [31:0] FB_BASE = 32'h30000000;
	localparam logic [26:0] BIOS_OFF = 27'd2097152;
	localparam logic [26:0] EXE_OFF  = 27'd4194304;

	// one download plus the video options applied with it
	typedef struct packed {
		logic [7:0]                 index;
		logic [26:0]                start;
		logic [7:0]                 beats;
		psx_loader_pkg::fb_opts_t   opts;
		psx_loader_pkg::disp_geom_t disp;
		logic [26:0]                exp_off;
		logic [1:0]                 exp_ch;
	} case_t;

	logic                         clk_1x;
	logic                         arst_n;
	logic                         download;
	psx_loader_pkg::loader_beat_t beat;
	wire                          load_wait;
	psx_loader_pkg::ram_write_t   main_wr;
	psx_loader_pkg::ram_write_t   cd_wr;
	wire                          main_ack;
	wire                          cd_ack;
	wire                          exe_load;
	wire                          core_reset;
	wire [29:0]                   cd_size;
	psx_loader_pkg::fb_opts_t     fb_opts;
	psx_loader_pkg::disp_geom_t   disp;
	psx_loader_pkg::fb_cfg_t      fb_cfg;

	case_t       cases [N_CASES];
	logic [58:0] main_q [$];
	logic [58:0] cd_q [$];
	integer      seed = 18;
	int          n_checks;
	int          n_errors;

	psx_loader_top uut (
		.clk_1x(clk_1x), .arst_n(arst_n), .download(download), .beat(beat),
		.load_wait(load_wait), .main_wr(main_wr), .main_ack(main_ack),
		.cd_wr(cd_wr), .cd_ack(cd_ack), .exe_load(exe_load),
		.core_reset(core_reset), .cd_size(cd_size), .fb_opts(fb_opts),
		.disp(disp), .fb_cfg(fb_cfg)
	);

	mem_ack_model u_mem (
		.clk_1x(clk_1x), .arst_n(arst_n), .main_req(main_wr.req),
		.cd_req(cd_wr.req), .main_ack(main_ack), .cd_ack(cd_ack)
	);

	always #5 clk_1x = ~clk_1x;

	// one queue entry per channel req cycle
	always @(negedge clk_1x) begin
		if (arst_n && main_wr.req) main_q.push_back({main_wr.addr, main_wr.data});
		if (arst_n && cd_wr.req) cd_q.push_back({cd_wr.addr, cd_wr.data});
	end

	task automatic check(input string name, input logic [63:0] expected,
	                     input logic [63:0] actual);
		n_checks++;
		if (expected !== actual) begin
			n_errors++;
			$display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic set_case(input int i, input logic [7:0] index, input logic [26:0] start,
	                        input int beats, input logic [2:0] opts,
	                        input logic [11:0] w, input logic [11:0] h,
	                        input logic [9:0] ox, input logic [8:0] oy,
	                        input logic [26:0] off, input logic [1:0] ch);
		cases[i].index   = index;
		cases[i].start   = start;
		cases[i].beats   = 8'(beats);
		cases[i].opts    = opts;
		cases[i].disp    = {w, h, ox, oy};
		cases[i].exp_off = off;
		cases[i].exp_ch  = ch;
	endtask

	// loader must be released once the channel acks
	task automatic wait_release(input string name);
		int cycles;
		cycles = 0;
		while (load_wait && cycles < 40) begin
			@(negedge clk_1x);
			cycles++;
		end
		if (load_wait) begin
			n_errors++;
			$display("%s: wait flag never cleared after the write", name);
			$display("checks %0d, errors %0d", n_checks, n_errors);
			$display("FAIL: see errors above");
			$finish;
		end
	endtask

	task automatic check_fb(input string name, input case_t c);
		logic [31:0] exp_base;
		exp_base = FB_BASE + 32'(c.disp.offset_x) * 32'd2 + 32'(c.disp.offset_y) * 32'd2048;
		check({name, " fb en"}, 64'(c.opts.fb_on), 64'(fb_cfg.en));
		check({name, " fb format"}, c.opts.color24 ? 64'h05 : 64'h0c, 64'(fb_cfg.format));
		if (c.opts.vram_view) begin
			check({name, " fb width"}, 64'd1024, 64'(fb_cfg.width));
			check({name, " fb height"}, 64'd512, 64'(fb_cfg.height));
			check({name, " fb base"}, 64'(FB_BASE), 64'(fb_cfg.base));
		end else begin
			check({name, " fb width"}, 64'(c.disp.width), 64'(fb_cfg.width));
			check({name, " fb height"}, 64'(c.disp.height), 64'(fb_cfg.height));
			check({name, " fb base"}, 64'(exp_base), 64'(fb_cfg.base));
		end
	endtask

	//========================================
	// one download from the table
	//========================================
	task automatic run_case(input int i);
		case_t       c;
		string       name;
		logic [26:0] addr;
		logic [26:0] even_addr;
		logic [15:0] data;
		logic [15:0] lo;
		logic [58:0] exp_q [$];
		int          pulses;
		int          pulse_at;
		c = cases[i];
		name = $sformatf("case%0d", i);
		main_q.delete();
		cd_q.delete();
		fb_opts = c.opts;
		disp = c.disp;
		download = 1'b1;
		beat.index = c.index;
		beat.wr = 1'b0;
		// one idle cycle for the registered decode
		@(negedge clk_1x);
		check({name, " core_reset"}, 64'(c.exp_ch != CH_NONE), 64'(core_reset));
		for (int b = 0; b < int'(c.beats); b++) begin
			addr = c.start + 27'(2 * b);
			data = 16'($random(seed));
			beat.wr = 1'b1;
			beat.addr = addr;
			beat.data = data;
			if (b % 2 == 0) begin
				lo = data;
				even_addr = addr;
			end else begin
				exp_q.push_back({27'(even_addr + c.exp_off), data, lo});
			end
			@(negedge clk_1x);
			beat.wr = 1'b0;
			// odd half completes a word
			if (b % 2 == 1) begin
				check({name, " wait rise"}, 64'(c.exp_ch != CH_NONE), 64'(load_wait));
				wait_release(name);
			end
		end
		download = 1'b0;
		// exe pulse lands 2 cycles after download falls
		pulses = 0;
		pulse_at = 0;
		for (int j = 1; j <= 8; j++) begin
			@(negedge clk_1x);
			if (exe_load) begin
				pulses++;
				pulse_at = j;
			end
		end
		check({name, " exe pulses"}, (c.index == 8'd1) ? 64'd1 : 64'd0, 64'(pulses));
		if (c.index == 8'd1) begin
			check({name, " exe pulse cycle"}, 64'd2, 64'(pulse_at));
		end
		check({name, " core_reset end"}, 64'd0, 64'(core_reset));
		check({name, " main count"}, (c.exp_ch == CH_MAIN) ? 64'(exp_q.size()) : 64'd0,
		      64'(main_q.size()));
		check({name, " cd count"}, (c.exp_ch == CH_CD) ? 64'(exp_q.size()) : 64'd0,
		      64'(cd_q.size()));
		for (int k = 0; k < exp_q.size(); k++) begin
			if (c.exp_ch == CH_MAIN && k < main_q.size()) begin
				check($sformatf("%s main word %0d", name, k), 64'(exp_q[k]), 64'(main_q[k]));
			end
			if (c.exp_ch == CH_CD && k < cd_q.size()) begin
				check($sformatf("%s cd word %0d", name, k), 64'(exp_q[k]), 64'(cd_q[k]));
			end
		end
		if (c.exp_ch == CH_CD) begin
			check({name, " cd_size"}, 64'(c.start + 27'(2 * (int'(c.beats) - 1))),
			      64'(cd_size));
		end
		check_fb(name, c);
	endtask

	initial begin
		clk_1x = 1'b0;
		arst_n = 1'b0;
		download = 1'b0;
		beat = '0;
		fb_opts = '0;
		disp = '0;
		n_checks = 0;
		n_errors = 0;
		// idx    start        beats opts    w    h    ox    oy   offset    channel
		set_case(0, 8'd0, 27'h000100, 8, 3'b100, 12'd320, 12'd240, 10'd0, 9'd0,
		         BIOS_OFF, CH_MAIN);
		set_case(1, 8'd1, 27'h000800, 6, 3'b110, 12'd640, 12'd480, 10'd16, 9'd8,
		         EXE_OFF, CH_MAIN);
		set_case(2, 8'd2, 27'h001000, 10, 3'b101, 12'd256, 12'd224, 10'd100, 9'd50,
		         27'd0, CH_CD);
		// beats of an unknown index are dropped
		set_case(3, 8'd5, 27'h000040, 4, 3'b010, 12'd512, 12'd240, 10'd7, 9'd3,
		         27'd0, CH_NONE);
		set_case(4, 8'h42, 27'h020000, 4, 3'b111, 12'd368, 12'd240, 10'd1023, 9'd511,
		         27'd0, CH_CD);
		set_case(5, 8'd1, 27'h000000, 2, 3'b000, 12'd320, 12'd256, 10'd300, 9'd200,
		         EXE_OFF, CH_MAIN);
		set_case(6, 8'd0, 27'h03fff0, 4, 3'b110, 12'd640, 12'd240, 10'd12, 9'd34,
		         BIOS_OFF, CH_MAIN);
		repeat (10) @(negedge clk_1x);
		// outputs while still in reset
		check("reset wait", 64'd0, 64'(load_wait));
		check("reset exe_load", 64'd0, 64'(exe_load));
		check("reset main req", 64'd0, 64'(main_wr.req));
		check("reset cd req", 64'd0, 64'(cd_wr.req));
		check("reset core_reset", 64'd0, 64'(core_reset));
		check("reset cd_size", 64'd0, 64'(cd_size));
		check("reset fb_cfg", 64'd0, 64'(fb_cfg));
		arst_n = 1'b1;
		repeat (2) @(negedge clk_1x);
		for (int i = 0; i < N_CASES; i++) begin
			run_case(i);
		end
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: psx_loader.f
+incdir+logic
logic/psx_loader_pkg.sv
logic/download_decode.sv
logic/word_packer.sv
logic/ram_write_router.sv
logic/framebuffer_setup.sv
logic/psx_loader_top.sv
dv/mem_ack_model.sv
dv/psx_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the loader testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f psx_loader.f \
	--top-module psx_loader_tb \
	-Mdir obj_dir -o psx_loader_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/psx_loader_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi
